// ==== mf2_pkg.sv ====
// Multiface Two shared definitions
// Addresses, port values and shadow cells

package mf2_pkg;

	//////////////////////////////
	// Cartridge memory map
	//////////////////////////////

	// 8 KB cartridge RAM
	localparam int MF2_RAM_AW = 13;

	// M1 fetch addresses that page in and hide the cartridge
	localparam logic [15:0] MF2_NMI_VEC  = 16'h0066;
	localparam logic [15:0] MF2_HIDE_VEC = 16'h0065;

	// FEE8 and FEEA share the top 14 address bits, bit 1 selects out/in
	localparam logic [13:0] MF2_CTRL_PORT = 14'h3FBA;

	// Top three address bits of the ROM and RAM windows
	localparam logic [2:0] MF2_ROM_PAGE = 3'd0;
	localparam logic [2:0] MF2_RAM_PAGE = 3'd1;

	//////////////////////////////
	// Shadowed hardware ports
	//////////////////////////////

	// High address bytes of the ports that get a shadow copy
	localparam logic [7:0] GA_PORT_HI     = 8'h7F;
	localparam logic [7:0] CRTC_SEL_HI    = 8'hBC;
	localparam logic [7:0] CRTC_VAL_HI    = 8'hBD;
	localparam logic [7:0] PPI_PORT_HI    = 8'hF7;
	localparam logic [7:0] ROMSEL_PORT_HI = 8'hDF;

	// Shadow cells inside the cartridge RAM
	localparam logic [12:0] SH_PEN_IDX   = 13'h1FCF;
	localparam logic [12:0] SH_BORDER    = 13'h1FDF;
	localparam logic [8:0]  SH_PEN_BASE  = 9'h1F9;
	localparam logic [12:0] SH_MODE      = 13'h1FEF;
	localparam logic [12:0] SH_BANK      = 13'h1FFF;
	localparam logic [12:0] SH_CRTC_SEL  = 13'h1CFF;
	localparam logic [8:0]  SH_CRTC_BASE = 9'h1DB;
	localparam logic [12:0] SH_PPI       = 13'h17FF;
	localparam logic [12:0] SH_ROMSEL    = 13'h1AAC;

	//////////////////////////////
	// Written byte views
	//////////////////////////////

	// Gate array function in data bits 7:6
	typedef enum logic [1:0] {
		GA_PEN_SEL = 2'b00,
		GA_COLOUR  = 2'b01,
		GA_MODE    = 2'b10,
		GA_BANKING = 2'b11
	} ga_func_e;

	// Same data byte seen as a gate array command or a CRTC select
	typedef union packed {
		struct packed {
			ga_func_e   func;
			logic       spare;
			logic       border;
			logic [3:0] pen;
		} ga;
		struct packed {
			logic [3:0] hi;
			logic [3:0] reg_idx;
		} crtc;
	} io_byte_u;

endpackage

// ==== mf2_io_decode.sv ====
`timescale 1ns/100ps
// Multiface Two bus decode

module mf2_io_decode (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic [15:0]                    cpu_addr,
	input  logic [7:0]                     cpu_dout,
	input  logic                           io_wr,
	input  logic                           m1,
	input  logic                           freeze_key,
	output logic                           nmi_press,
	output logic                           fetch_nmi_vec,
	output logic                           fetch_hide_vec,
	output logic                           ctrl_wr,
	output logic                           ctrl_page_in,
	output logic                           store_wr,
	output logic [mf2_pkg::MF2_RAM_AW-1:0] store_addr,
	output logic                           in_rom_win,
	output logic                           in_ram_win
);
	import mf2_pkg::*;

	logic       io_wr_q;
	logic       m1_q;
	logic       key_q;
	logic       io_wr_rise;
	logic       m1_rise;
	logic [7:0] port_hi;
	io_byte_u   wr_byte;
	logic       store_hit;
	logic       pen_border;
	logic [3:0] pen_idx;
	logic [3:0] crtc_idx;

	//////////////////////////////
	// Strobe edges
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			m1_q    <= 1'b0;
			key_q   <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			m1_q    <= m1;
			key_q   <= freeze_key;
		end
	end

	assign io_wr_rise = io_wr & ~io_wr_q;
	assign m1_rise    = m1 & ~m1_q;
	assign nmi_press  = freeze_key & ~key_q;

	// Opcode fetches at the two vectors
	assign fetch_nmi_vec  = m1_rise & (cpu_addr == MF2_NMI_VEC);
	assign fetch_hide_vec = m1_rise & (cpu_addr == MF2_HIDE_VEC);

	// FEE8 pages in, FEEA pages out
	assign ctrl_wr      = io_wr_rise & (cpu_addr[15:2] == MF2_CTRL_PORT);
	assign ctrl_page_in = ~cpu_addr[1];

	assign in_rom_win = cpu_addr[15:13] == MF2_ROM_PAGE;
	assign in_ram_win = cpu_addr[15:13] == MF2_RAM_PAGE;

	//////////////////////////////
	// Shadow cell selection
	//////////////////////////////

	assign port_hi = cpu_addr[15:8];
	assign wr_byte = cpu_dout;

	always_comb begin
		store_hit  = 1'b1;
		store_addr = '0;
		case (port_hi)
			GA_PORT_HI: begin
				case (wr_byte.ga.func)
					GA_PEN_SEL: store_addr = SH_PEN_IDX;
					// Border or one of the 16 pen cells
					GA_COLOUR:  store_addr = pen_border ? SH_BORDER : {SH_PEN_BASE, pen_idx};
					GA_MODE:    store_addr = SH_MODE;
					default:    store_addr = SH_BANK;
				endcase
			end
			CRTC_SEL_HI:    store_addr = SH_CRTC_SEL;
			CRTC_VAL_HI:    store_addr = {SH_CRTC_BASE, crtc_idx};
			PPI_PORT_HI:    store_addr = SH_PPI;
			ROMSEL_PORT_HI: store_addr = SH_ROMSEL;
			default:        store_hit  = 1'b0;
		endcase
	end

	assign store_wr = io_wr_rise & store_hit;

	// Last pen and CRTC register selected, needed by the following writes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_border <= 1'b0;
			pen_idx    <= '0;
			crtc_idx   <= '0;
		end else if (store_wr) begin
			if (port_hi == GA_PORT_HI && wr_byte.ga.func == GA_PEN_SEL) begin
				pen_border <= wr_byte.ga.border;
				pen_idx    <= wr_byte.ga.pen;
			end
			if (port_hi == CRTC_SEL_HI) begin
				crtc_idx <= wr_byte.crtc.reg_idx;
			end
		end
	end

endmodule

// ==== mf2_control.sv ====
`timescale 1ns/100ps
// Multiface Two paging and RAM port control

module mf2_control (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           nmi_press,
	input  logic                           fetch_nmi_vec,
	input  logic                           fetch_hide_vec,
	input  logic                           ctrl_wr,
	input  logic                           ctrl_page_in,
	input  logic                           store_wr,
	input  logic [mf2_pkg::MF2_RAM_AW-1:0] store_addr,
	input  logic                           in_rom_win,
	input  logic                           in_ram_win,
	input  logic [7:0]                     cpu_dout,
	input  logic [mf2_pkg::MF2_RAM_AW-1:0] mem_addr,
	input  logic                           mem_rd,
	input  logic                           mem_wr,
	input  logic                           cfg_disable,
	input  logic                           cfg_hide,
	output logic                           mf2_nmi,
	output logic                           mf2_active,
	output logic                           rom_sel,
	output logic                           ram_sel,
	output logic                           ram_rd_sel,
	output logic [mf2_pkg::MF2_RAM_AW-1:0] ram_addr,
	output logic [7:0]                     ram_wdata,
	output logic                           ram_we
);
	import mf2_pkg::*;

	logic                  hidden;
	logic                  port_we;
	logic [MF2_RAM_AW-1:0] port_addr;

	//////////////////////////////
	// NMI and paging state
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mf2_nmi    <= 1'b0;
			mf2_active <= 1'b0;
			hidden     <= cfg_disable | cfg_hide;
		end else begin
			// Freeze button only counts while paged out
			if (nmi_press && !mf2_active && !cfg_disable) begin
				mf2_nmi <= 1'b1;
			end
			// NMI handler entry
			if (fetch_nmi_vec && mf2_nmi) begin
				mf2_active <= 1'b1;
				hidden     <= 1'b0;
				mf2_nmi    <= 1'b0;
			end
			if (fetch_hide_vec && mf2_active) begin
				hidden <= 1'b1;
			end
			if (ctrl_wr) begin
				mf2_active <= ctrl_page_in & ~hidden & ~cfg_disable;
			end
		end
	end

	// Windows only exist while paged in
	assign rom_sel    = mf2_active & in_rom_win;
	assign ram_sel    = mf2_active & in_ram_win;
	assign ram_rd_sel = mem_rd & ram_sel;

	//////////////////////////////
	// RAM port arbitration
	//////////////////////////////

	always_comb begin
		port_we   = 1'b0;
		port_addr = mem_addr;
		if (ctrl_wr) begin
			// Control port cycle, no RAM access
			port_we = 1'b0;
		end else if (store_wr) begin
			port_we   = 1'b1;
			port_addr = store_addr;
		end else if (mem_wr && ram_sel) begin
			port_we = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_we <= 1'b0;
		end else begin
			ram_we <= port_we;
		end
	end

	always_ff @(posedge clk_sys) begin
		ram_addr  <= port_addr;
		ram_wdata <= cpu_dout;
	end

endmodule

// ==== mf2_ram.sv ====
`timescale 1ns/100ps
// Multiface Two cartridge RAM

module mf2_ram (
	input  logic                           clk_sys,
	input  logic [mf2_pkg::MF2_RAM_AW-1:0] ram_addr,
	input  logic [7:0]                     ram_wdata,
	input  logic                           ram_we,
	input  logic                           ram_rd_sel,
	output logic [7:0]                     dout
);
	import mf2_pkg::*;

	logic [7:0] mem [2**MF2_RAM_AW];
	logic [7:0] rd_q;

	//////////////////////////////
	// Storage and read register
	//////////////////////////////

	// Write data shows up on the read register in the same cycle
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
			rd_q          <= ram_wdata;
		end else begin
			rd_q <= mem[ram_addr];
		end
	end

	// Wired-AND read bus, all ones when not selected
	assign dout = ram_rd_sel ? rd_q : 8'hFF;

endmodule

// ==== mf2_top.sv ====
`timescale 1ns/100ps
// Multiface Two cartridge top level

module mf2_top (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic [15:0]                    cpu_addr,
	input  logic [7:0]                     cpu_dout,
	input  logic                           mem_rd,
	input  logic                           mem_wr,
	input  logic                           io_wr,
	input  logic                           m1,
	input  logic [mf2_pkg::MF2_RAM_AW-1:0] mem_addr,
	input  logic                           freeze_key,
	input  logic                           cfg_disable,
	input  logic                           cfg_hide,
	output logic                           mf2_nmi,
	output logic                           mf2_active,
	output logic                           rom_sel,
	output logic                           ram_sel,
	output logic [7:0]                     dout
);
	import mf2_pkg::*;

	// Decode to control
	logic                  nmi_press;
	logic                  fetch_nmi_vec;
	logic                  fetch_hide_vec;
	logic                  ctrl_wr;
	logic                  ctrl_page_in;
	logic                  store_wr;
	logic [MF2_RAM_AW-1:0] store_addr;
	logic                  in_rom_win;
	logic                  in_ram_win;

	// Control to RAM
	logic [MF2_RAM_AW-1:0] ram_addr;
	logic [7:0]            ram_wdata;
	logic                  ram_we;
	logic                  ram_rd_sel;

	mf2_io_decode i_decode (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cpu_addr       (cpu_addr),
		.cpu_dout       (cpu_dout),
		.io_wr          (io_wr),
		.m1             (m1),
		.freeze_key     (freeze_key),
		.nmi_press      (nmi_press),
		.fetch_nmi_vec  (fetch_nmi_vec),
		.fetch_hide_vec (fetch_hide_vec),
		.ctrl_wr        (ctrl_wr),
		.ctrl_page_in   (ctrl_page_in),
		.store_wr       (store_wr),
		.store_addr     (store_addr),
		.in_rom_win     (in_rom_win),
		.in_ram_win     (in_ram_win)
	);

	mf2_control i_control (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.nmi_press      (nmi_press),
		.fetch_nmi_vec  (fetch_nmi_vec),
		.fetch_hide_vec (fetch_hide_vec),
		.ctrl_wr        (ctrl_wr),
		.ctrl_page_in   (ctrl_page_in),
		.store_wr       (store_wr),
		.store_addr     (store_addr),
		.in_rom_win     (in_rom_win),
		.in_ram_win     (in_ram_win),
		.cpu_dout       (cpu_dout),
		.mem_addr       (mem_addr),
		.mem_rd         (mem_rd),
		.mem_wr         (mem_wr),
		.cfg_disable    (cfg_disable),
		.cfg_hide       (cfg_hide),
		.mf2_nmi        (mf2_nmi),
		.mf2_active     (mf2_active),
		.rom_sel        (rom_sel),
		.ram_sel        (ram_sel),
		.ram_rd_sel     (ram_rd_sel),
		.ram_addr       (ram_addr),
		.ram_wdata      (ram_wdata),
		.ram_we         (ram_we)
	);

	mf2_ram i_ram (
		.clk_sys    (clk_sys),
		.ram_addr   (ram_addr),
		.ram_wdata  (ram_wdata),
		.ram_we     (ram_we),
		.ram_rd_sel (ram_rd_sel),
		.dout       (dout)
	);

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/100ps
// Testbench clock and reset

module tb_clock (
	input  logic restart,
	output logic clk_sys,
	output logic reset
);
	int unsigned rst_cnt = 0;

	// 40 ns period
	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	// Reset held for 16 cycles, again after each restart request
	always @(posedge clk_sys) begin
		if (restart) begin
			rst_cnt <= 0;
		end else if (rst_cnt < 16) begin
			rst_cnt <= rst_cnt + 1;
		end
	end

	assign reset = rst_cnt < 16;

endmodule

// ==== tb_mf2.sv ====
`timescale 1ns/100ps
// Multiface Two testbench

module tb_mf2;
	localparam int MAX_CASES = 128;
	localparam int WORDS     = 4;

	// Operation codes in the cases file
	localparam logic [3:0] OP_END    = 4'h0;
	localparam logic [3:0] OP_IO_WR  = 4'h1;
	localparam logic [3:0] OP_MEM_WR = 4'h2;
	localparam logic [3:0] OP_MEM_RD = 4'h3;
	localparam logic [3:0] OP_FETCH  = 4'h4;
	localparam logic [3:0] OP_KEY    = 4'h5;
	localparam logic [3:0] OP_FLAGS  = 4'h6;
	localparam logic [3:0] OP_RESET  = 4'h7;
	localparam logic [3:0] OP_RANDOM = 4'h8;

	// Shadow cells as seen through the RAM window at 0x2000
	localparam logic [15:0] CRTC_SEL_CELL  = 16'h3CFF;
	localparam logic [15:0] CRTC_REG_CELLS = 16'h3DB0;
	localparam logic [15:0] PEN_IDX_CELL   = 16'h3FCF;
	localparam logic [15:0] PEN_CELLS      = 16'h3F90;
	localparam logic [15:0] BORDER_CELL    = 16'h3FDF;

	logic        clk_sys;
	logic        reset;
	logic        restart;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        mem_rd;
	logic        mem_wr;
	logic        io_wr;
	logic        m1;
	logic [12:0] mem_addr;
	logic        freeze_key;
	logic        cfg_disable;
	logic        cfg_hide;
	logic        mf2_nmi;
	logic        mf2_active;
	logic        rom_sel;
	logic        ram_sel;
	logic [7:0]  dout;

	logic [15:0] case_words [WORDS*MAX_CASES];
	int          n_cases  = 0;
	int          n_checks = 0;
	int          cycles   = 0;
	int          limit    = 100;
	int          seed     = 69970;

	tb_clock i_clock (
		.restart (restart),
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	mf2_top i_dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.mem_rd      (mem_rd),
		.mem_wr      (mem_wr),
		.io_wr       (io_wr),
		.m1          (m1),
		.mem_addr    (mem_addr),
		.freeze_key  (freeze_key),
		.cfg_disable (cfg_disable),
		.cfg_hide    (cfg_hide),
		.mf2_nmi     (mf2_nmi),
		.mf2_active  (mf2_active),
		.rom_sel     (rom_sel),
		.ram_sel     (ram_sel),
		.dout        (dout)
	);

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Timeout after %0d cycles, the cases did not finish", cycles);
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	//////////////////////////////
	// Bus operations
	//////////////////////////////

	// Strobe held for three cycles, released for two
	task automatic bus_op(input logic [3:0] op, input logic [15:0] addr,
		input logic [7:0] data, output logic [7:0] rd, output logic [3:0] flags);
		@(posedge clk_sys);
		cpu_addr   <= addr;
		mem_addr   <= addr[12:0];
		cpu_dout   <= data;
		io_wr      <= (op == OP_IO_WR);
		mem_wr     <= (op == OP_MEM_WR);
		mem_rd     <= (op == OP_MEM_RD);
		m1         <= (op == OP_FETCH);
		freeze_key <= (op == OP_KEY);
		repeat (2) @(posedge clk_sys);
		// Read data settles at the second edge
		@(negedge clk_sys);
		rd    = dout;
		flags = {mf2_nmi, mf2_active, rom_sel, ram_sel};
		@(posedge clk_sys);
		io_wr      <= 1'b0;
		mem_wr     <= 1'b0;
		mem_rd     <= 1'b0;
		m1         <= 1'b0;
		freeze_key <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic run_op(input logic [3:0] op, input logic [15:0] addr,
		input logic [7:0] data, input logic [7:0] exp);
		logic [7:0] rd;
		logic [3:0] flags;
		bus_op(op, addr, data, rd, flags);
		if (op == OP_MEM_RD) begin
			check_value($sformatf("dout at %h", addr), {8'h00, rd}, {8'h00, exp});
		end else if (op == OP_FLAGS) begin
			check_value($sformatf("{mf2_nmi,mf2_active,rom_sel,ram_sel} at %h", addr),
				{12'h000, flags}, {12'h000, exp[3:0]});
		end
	endtask

	task automatic wait_reset_low;
		do @(posedge clk_sys); while (reset);
	endtask

	task automatic apply_reset(input logic [7:0] cfg);
		@(posedge clk_sys);
		cfg_disable <= cfg[0];
		cfg_hide    <= cfg[1];
		restart     <= 1'b1;
		@(posedge clk_sys);
		restart <= 1'b0;
		wait_reset_low();
	endtask

	// CRTC select and value, then pen select and colour, each read back
	task automatic random_shadow_pairs(input int count);
		logic [31:0] r;
		logic [7:0]  sel;
		logic [7:0]  val;
		logic [7:0]  pen;
		logic [7:0]  colour;
		logic [15:0] colour_addr;
		for (int i = 0; i < count; i++) begin
			r      = $random(seed);
			sel    = r[7:0];
			val    = r[15:8];
			pen    = {2'b00, r[21:16]};
			colour = {2'b01, r[29:24]};
			colour_addr = pen[4] ? BORDER_CELL : PEN_CELLS + {12'h000, pen[3:0]};
			run_op(OP_IO_WR, 16'hBC00, sel, 8'h00);
			run_op(OP_IO_WR, 16'hBD00, val, 8'h00);
			run_op(OP_MEM_RD, CRTC_SEL_CELL, 8'h00, sel);
			run_op(OP_MEM_RD, CRTC_REG_CELLS + {12'h000, sel[3:0]}, 8'h00, val);
			run_op(OP_IO_WR, 16'h7F00, pen, 8'h00);
			run_op(OP_IO_WR, 16'h7F00, colour, 8'h00);
			run_op(OP_MEM_RD, PEN_IDX_CELL, 8'h00, pen);
			run_op(OP_MEM_RD, colour_addr, 8'h00, colour);
		end
	endtask

	task automatic run_case(input int idx);
		logic [3:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  exp;
		op   = case_words[WORDS*idx][3:0];
		addr = case_words[WORDS*idx+1];
		data = case_words[WORDS*idx+2][7:0];
		exp  = case_words[WORDS*idx+3][7:0];
		case (op)
			OP_RESET:  apply_reset(data);
			OP_RANDOM: random_shadow_pairs(int'(addr));
			default:   run_op(op, addr, data, exp);
		endcase
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		logic [3:0] op;
		int         units;
		restart     <= 1'b0;
		cpu_addr    <= '0;
		cpu_dout    <= '0;
		mem_rd      <= 1'b0;
		mem_wr      <= 1'b0;
		io_wr       <= 1'b0;
		m1          <= 1'b0;
		mem_addr    <= '0;
		freeze_key  <= 1'b0;
		cfg_disable <= 1'b0;
		cfg_hide    <= 1'b0;
		$readmemh("mf2_cases.txt", case_words);

		// Count cases and size the cycle budget, 8 cycles per operation
		units = 0;
		while (n_cases < MAX_CASES && !$isunknown(case_words[WORDS*n_cases])
			&& case_words[WORDS*n_cases][3:0] != OP_END) begin
			op = case_words[WORDS*n_cases][3:0];
			if (op == OP_RESET) begin
				units += 4;
			end else if (op == OP_RANDOM) begin
				units += 8 * int'(case_words[WORDS*n_cases+1]);
			end else begin
				units += 1;
			end
			n_cases++;
		end
		limit = 100 + 8 * units;

		wait_reset_low();
		for (int i = 0; i < n_cases; i++) begin
			run_case(i);
		end
		if (n_cases > 0 && n_checks > 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("No test cases were read from mf2_cases.txt");
			$display("TESTS FAILED");
			$fatal(1, "no cases");
		end
	end

endmodule

// ==== mf2_cases.txt ====
// Columns: op addr data expect, all hex
// op 1 io wr, 2 mem wr, 3 mem rd, 4 M1 fetch, 5 key, 6 flags {nmi,active,rom,ram},
// op 7 reset with data {hide,disable}, 8 random shadow pairs (addr = count), 0 end
// Inactive after reset
6 2000 00 00
3 2000 00 FF
// Freeze, then NMI vector fetch pages in
5 0000 00 00
6 0000 00 08
4 0066 00 00
6 0000 00 06
6 1FFF 00 06
6 2000 00 05
6 3FFF 00 05
6 4000 00 04
// RAM window
2 2000 A5 00
3 2000 00 A5
2 3ABC 5A 00
3 3ABC 00 5A
3 4000 00 FF
3 1000 00 FF
// Shadow stores: pen 3, its colour, then border
1 7F00 03 00
3 3FCF 00 03
1 7F00 4C 00
3 3F93 00 4C
1 7F00 10 00
3 3FCF 00 10
1 7F00 55 00
3 3FDF 00 55
// CRTC register 12
1 BC00 0C 00
3 3CFF 00 0C
1 BD00 30 00
3 3DBC 00 30
// Mode, banking, 8255 control, upper ROM
1 7F00 8D 00
3 3FEF 00 8D
1 7F00 C4 00
3 3FFF 00 C4
1 F700 82 00
3 37FF 00 82
1 DF00 07 00
3 3AAC 00 07
8 0010 00 00
// Control ports
1 FEEA 00 00
6 2000 00 00
3 2000 00 FF
1 FEE8 00 00
6 2000 00 05
3 2000 00 A5
// Hidden after 0065 fetch
4 0065 00 00
6 4000 00 04
1 FEEA 00 00
1 FEE8 00 00
6 4000 00 00
4 0066 00 00
6 4000 00 00
5 0000 00 00
6 4000 00 08
4 0066 00 00
6 4000 00 04
// Hide and disable levels
7 0000 02 00
1 FEE8 00 00
6 4000 00 00
7 0000 01 00
5 0000 00 00
6 4000 00 00
1 FEE8 00 00
6 4000 00 00
0 0000 00 00

// ==== flist.f ====
mf2_pkg.sv
mf2_io_decode.sv
mf2_control.sv
mf2_ram.sv
mf2_top.sv
tb_clock.sv
tb_mf2.sv

// ==== Makefile ====
# Verilator simulation of the Multiface Two block

VERILATOR ?= verilator
TOP       ?= tb_mf2
FLIST     ?= flist.f
CASES     ?= mf2_cases.txt
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 --timescale 1ns/100ps

SRCS := $(shell cat $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM) $(CASES)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
